// ==== include/lsq_consts.svh ====
`ifndef LSQ_CONSTS_SVH
`define LSQ_CONSTS_SVH

// memory operations per bundle, in program order
`define LSQ_SLOTS 6

// instruction entries a bundle retires into
`define LSQ_INSTS 10

// 4-byte banks in one 64-byte cache line
`define LSQ_BANKS 16

// byte address width
`define LSQ_ADDR_W 20

`endif

// ==== source/lsqPkg.sv ====
`include "lsq_consts.svh"

package lsqPkg;

  // byte address
  typedef logic [`LSQ_ADDR_W-1:0] lsAddr;

  // line number, address without the 6 offset bits
  typedef logic [`LSQ_ADDR_W-7:0] lineTag;

  // banks touched inside one line
  typedef logic [`LSQ_BANKS-1:0] bankMask;

  // access size in bytes, legal range 1..16
  typedef logic [4:0] accSize;

  // instruction entry number
  typedef logic [3:0] instIdx;

  // one bit per slot
  typedef logic [`LSQ_SLOTS-1:0] slotMask;

  // one bit per instruction entry
  typedef logic [`LSQ_INSTS-1:0] instMask;

endpackage

// ==== source/lsqAddrDecode.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsqAddrDecode (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  lsqPkg::slotMask opValid,
  input  lsqPkg::slotMask opStore,
  input  lsqPkg::lsAddr   opAddr [`LSQ_SLOTS],
  input  lsqPkg::accSize  opSize [`LSQ_SLOTS],
  input  lsqPkg::instIdx  opInst [`LSQ_SLOTS],
  input  logic            take,
  output logic            ack,
  output logic            full,
  output lsqPkg::slotMask slotValid,
  output lsqPkg::slotMask slotStore,
  output lsqPkg::slotMask slotExcept,
  output lsqPkg::instIdx  slotInst [`LSQ_SLOTS],
  output lsqPkg::slotMask evenUse,
  output lsqPkg::slotMask oddUse,
  output lsqPkg::lineTag  evenTag [`LSQ_SLOTS],
  output lsqPkg::lineTag  oddTag [`LSQ_SLOTS],
  output lsqPkg::bankMask evenBanks [`LSQ_SLOTS],
  output lsqPkg::bankMask oddBanks [`LSQ_SLOTS]
);
  import lsqPkg::*;

  localparam int LineLsb = 6;
  localparam int PageLsb = 12;

  logic    capture;
  logic    ackPend;
  slotMask exceptN;
  slotMask evenUseN;
  slotMask oddUseN;
  lineTag  evenTagN [`LSQ_SLOTS];
  lineTag  oddTagN [`LSQ_SLOTS];
  bankMask evenBanksN [`LSQ_SLOTS];
  bankMask oddBanksN [`LSQ_SLOTS];

  // capture only into an empty register while ack is low
  assign capture = req && !ack && !full;

  for (genvar s = 0; s < `LSQ_SLOTS; s++) begin : gSlot
    lsAddr   lastByte;
    lineTag  firstLine;
    lineTag  lastLine;
    bankMask headMask;
    bankMask tailMask;
    bankMask firstBanks;
    logic    sizeBad;
    logic    pageCross;
    logic    split;
    logic    firstOdd;
    logic    ok;

    assign lastByte  = opAddr[s] + lsAddr'(opSize[s]) - lsAddr'(1);
    assign firstLine = opAddr[s][`LSQ_ADDR_W-1:LineLsb];
    assign lastLine  = lastByte[`LSQ_ADDR_W-1:LineLsb];

    assign sizeBad   = (opSize[s] == accSize'(0)) || (opSize[s] > accSize'(16));
    // a wrap past the top address also shows up as a page change
    assign pageCross = opAddr[s][`LSQ_ADDR_W-1:PageLsb] != lastByte[`LSQ_ADDR_W-1:PageLsb];
    assign exceptN[s] = opValid[s] && (sizeBad || pageCross);
    assign ok = opValid[s] && !sizeBad && !pageCross;

    assign split    = firstLine != lastLine;
    assign firstOdd = firstLine[0];

    // banks from the first byte upward, and up to the last byte
    assign headMask = {`LSQ_BANKS{1'b1}} << opAddr[s][LineLsb-1:2];
    assign tailMask = {`LSQ_BANKS{1'b1}} >> (4'(`LSQ_BANKS - 1) - lastByte[LineLsb-1:2]);
    assign firstBanks = split ? headMask : (headMask & tailMask);

    // two consecutive lines always differ in parity
    assign evenUseN[s] = ok && (!firstOdd || split);
    assign oddUseN[s]  = ok && (firstOdd || split);

    assign evenTagN[s] = firstOdd ? lastLine : firstLine;
    assign oddTagN[s]  = firstOdd ? firstLine : lastLine;

    assign evenBanksN[s] = !evenUseN[s] ? '0 : (firstOdd ? tailMask : firstBanks);
    assign oddBanksN[s]  = !oddUseN[s] ? '0 : (firstOdd ? firstBanks : tailMask);
  end

  // handshake and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      ack     <= 1'b0;
      ackPend <= 1'b0;
      full    <= 1'b0;
    end else begin
      if (capture) begin
        ackPend <= 1'b1;
      end else if (ackPend) begin
        ackPend <= 1'b0;
        ack     <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
      if (capture) begin
        full <= 1'b1;
      end else if (take) begin
        full <= 1'b0;
      end
    end
  end

  // decoded bundle
  always_ff @(posedge clk) begin
    if (capture) begin
      slotValid  <= opValid;
      slotStore  <= opStore;
      slotExcept <= exceptN;
      slotInst   <= opInst;
      evenUse    <= evenUseN;
      oddUse     <= oddUseN;
      evenTag    <= evenTagN;
      oddTag     <= oddTagN;
      evenBanks  <= evenBanksN;
      oddBanks   <= oddBanksN;
    end
  end

endmodule

// ==== source/lsqConflictCheck.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsqConflictCheck (
  input  logic            evenUse0,
  input  logic            oddUse0,
  input  lsqPkg::lineTag  evenTag0,
  input  lsqPkg::lineTag  oddTag0,
  input  lsqPkg::bankMask evenBanks0,
  input  lsqPkg::bankMask oddBanks0,
  input  logic            evenUse1,
  input  logic            oddUse1,
  input  lsqPkg::lineTag  evenTag1,
  input  lsqPkg::lineTag  oddTag1,
  input  lsqPkg::bankMask evenBanks1,
  input  lsqPkg::bankMask oddBanks1,
  output logic            confl
);
  import lsqPkg::*;

  bankMask evenShared;
  bankMask oddShared;
  logic    evenHit;
  logic    oddHit;

  assign evenShared = evenBanks0 & evenBanks1;
  assign oddShared  = oddBanks0 & oddBanks1;

  // full tag compare, no partial aliasing
  assign evenHit = evenUse0 && evenUse1 && (evenTag0 == evenTag1) && |evenShared;
  assign oddHit  = oddUse0 && oddUse1 && (oddTag0 == oddTag1) && |oddShared;

  assign confl = evenHit || oddHit;

endmodule

// ==== source/lsqConflictBundle.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsqConflictBundle (
  input  lsqPkg::slotMask slotStore,
  input  lsqPkg::slotMask slotValid,
  input  lsqPkg::slotMask evenUse,
  input  lsqPkg::slotMask oddUse,
  input  lsqPkg::lineTag  evenTag [`LSQ_SLOTS],
  input  lsqPkg::lineTag  oddTag [`LSQ_SLOTS],
  input  lsqPkg::bankMask evenBanks [`LSQ_SLOTS],
  input  lsqPkg::bankMask oddBanks [`LSQ_SLOTS],
  output lsqPkg::slotMask slotConfl
);
  import lsqPkg::*;

  // pairHit[h][k] set when later slot h overlaps earlier slot k
  slotMask pairHit [`LSQ_SLOTS];
  slotMask storeMask;

  assign storeMask = slotValid & slotStore;

  for (genvar h = 0; h < `LSQ_SLOTS; h++) begin : gLater
    for (genvar k = 0; k < `LSQ_SLOTS; k++) begin : gEarlier
      if (k < h) begin : gPair
        lsqConflictCheck i_lsqConflictCheck (
          .evenUse0   (evenUse[k]),
          .oddUse0    (oddUse[k]),
          .evenTag0   (evenTag[k]),
          .oddTag0    (oddTag[k]),
          .evenBanks0 (evenBanks[k]),
          .oddBanks0  (oddBanks[k]),
          .evenUse1   (evenUse[h]),
          .oddUse1    (oddUse[h]),
          .evenTag1   (evenTag[h]),
          .oddTag1    (oddTag[h]),
          .evenBanks1 (evenBanks[h]),
          .oddBanks1  (oddBanks[h]),
          .confl      (pairHit[h][k])
        );
      end else begin : gNone
        assign pairHit[h][k] = 1'b0;
      end
    end

    // only a valid load is checked, and only against stores
    assign slotConfl[h] = slotValid[h] && !slotStore[h] && |(pairHit[h] & storeMask);
  end

endmodule

// ==== source/lsqRetireDecide.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsqRetireDecide (
  input  logic            clk,
  input  logic            rst,
  input  logic            full,
  input  lsqPkg::slotMask slotValid,
  input  lsqPkg::slotMask slotExcept,
  input  lsqPkg::instIdx  slotInst [`LSQ_SLOTS],
  input  lsqPkg::slotMask slotConfl,
  input  logic            resAck,
  output logic            take,
  output logic            resReq,
  output lsqPkg::instMask retireEn,
  output lsqPkg::instMask retireFine,
  output lsqPkg::instMask retireLdConfl,
  output lsqPkg::instMask retireExcept,
  output lsqPkg::slotMask hasConfl
);
  import lsqPkg::*;

  typedef enum logic [1:0] {
    empty,
    loaded,
    waitLow
  } resState;

  resState state;
  instMask enN;
  instMask conflN;
  instMask exceptN;
  instMask fineN;

  // fold slot flags onto the entries they belong to
  always_comb begin
    enN     = '0;
    conflN  = '0;
    exceptN = '0;
    for (int i = 0; i < `LSQ_INSTS; i++) begin
      for (int s = 0; s < `LSQ_SLOTS; s++) begin
        if (slotValid[s] && (slotInst[s] == instIdx'(i))) begin
          enN[i]     = 1'b1;
          conflN[i]  = conflN[i] | slotConfl[s];
          exceptN[i] = exceptN[i] | slotExcept[s];
        end
      end
    end
  end

  assign fineN = enN & ~conflN & ~exceptN;

  // transfer from decode when a bundle waits and this stage is free
  assign take = full && (state == empty);

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= empty;
      resReq        <= 1'b0;
      retireEn      <= '0;
      retireFine    <= '0;
      retireLdConfl <= '0;
      retireExcept  <= '0;
      hasConfl      <= '0;
    end else begin
      case (state)
        empty: begin
          if (full) begin
            state         <= loaded;
            retireEn      <= enN;
            retireFine    <= fineN;
            retireLdConfl <= conflN;
            retireExcept  <= exceptN;
            hasConfl      <= slotConfl;
          end
        end
        loaded: begin
          // request goes up one cycle after the transfer
          if (!resReq) begin
            resReq <= 1'b1;
          end else if (resAck) begin
            resReq <= 1'b0;
            state  <= waitLow;
          end
        end
        waitLow: begin
          if (!resAck) begin
            state <= empty;
          end
        end
        default: begin
          state <= empty;
        end
      endcase
    end
  end

endmodule

// ==== source/lsqCheckTop.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsqCheckTop (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  lsqPkg::slotMask opValid,
  input  lsqPkg::slotMask opStore,
  input  lsqPkg::lsAddr   opAddr [`LSQ_SLOTS],
  input  lsqPkg::accSize  opSize [`LSQ_SLOTS],
  input  lsqPkg::instIdx  opInst [`LSQ_SLOTS],
  output logic            ack,
  input  logic            resAck,
  output logic            resReq,
  output lsqPkg::instMask retireEn,
  output lsqPkg::instMask retireFine,
  output lsqPkg::instMask retireLdConfl,
  output lsqPkg::instMask retireExcept,
  output lsqPkg::slotMask hasConfl
);
  import lsqPkg::*;

  logic    full;
  logic    take;
  slotMask slotValid;
  slotMask slotStore;
  slotMask slotExcept;
  slotMask slotConfl;
  instIdx  slotInst [`LSQ_SLOTS];
  slotMask evenUse;
  slotMask oddUse;
  lineTag  evenTag [`LSQ_SLOTS];
  lineTag  oddTag [`LSQ_SLOTS];
  bankMask evenBanks [`LSQ_SLOTS];
  bankMask oddBanks [`LSQ_SLOTS];

  lsqAddrDecode i_lsqAddrDecode (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .opValid    (opValid),
    .opStore    (opStore),
    .opAddr     (opAddr),
    .opSize     (opSize),
    .opInst     (opInst),
    .take       (take),
    .ack        (ack),
    .full       (full),
    .slotValid  (slotValid),
    .slotStore  (slotStore),
    .slotExcept (slotExcept),
    .slotInst   (slotInst),
    .evenUse    (evenUse),
    .oddUse     (oddUse),
    .evenTag    (evenTag),
    .oddTag     (oddTag),
    .evenBanks  (evenBanks),
    .oddBanks   (oddBanks)
  );

  lsqConflictBundle i_lsqConflictBundle (
    .slotStore (slotStore),
    .slotValid (slotValid),
    .evenUse   (evenUse),
    .oddUse    (oddUse),
    .evenTag   (evenTag),
    .oddTag    (oddTag),
    .evenBanks (evenBanks),
    .oddBanks  (oddBanks),
    .slotConfl (slotConfl)
  );

  lsqRetireDecide i_lsqRetireDecide (
    .clk           (clk),
    .rst           (rst),
    .full          (full),
    .slotValid     (slotValid),
    .slotExcept    (slotExcept),
    .slotInst      (slotInst),
    .slotConfl     (slotConfl),
    .resAck        (resAck),
    .take          (take),
    .resReq        (resReq),
    .retireEn      (retireEn),
    .retireFine    (retireFine),
    .retireLdConfl (retireLdConfl),
    .retireExcept  (retireExcept),
    .hasConfl      (hasConfl)
  );

endmodule

// ==== sim/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over four rising edges, released on the falling edge after the fourth
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// ==== sim/tbLsqCheck.sv ====
`timescale 1ns/1ps
`include "lsq_consts.svh"

module tbLsqCheck;
  import lsqPkg::*;

  localparam int NumBundles = 300;
  localparam int FoldStart = 200;
  localparam int SlowStart = 250;
  localparam int Timeout = 300;

  logic    clk;
  logic    rst;
  logic    req;
  slotMask opValid;
  slotMask opStore;
  lsAddr   opAddr [`LSQ_SLOTS];
  accSize  opSize [`LSQ_SLOTS];
  instIdx  opInst [`LSQ_SLOTS];
  logic    ack;
  logic    resAck;
  logic    resReq;
  instMask retireEn;
  instMask retireFine;
  instMask retireLdConfl;
  instMask retireExcept;
  slotMask hasConfl;

  logic [31:0] seed;
  // separate stream for the response delays
  logic [31:0] ackSeed;
  int          errors;
  int          checks;
  int          accepted;
  int          retired;
  int          maxInFlight;
  logic        slowAck;
  logic        ackPrev;
  logic        reqPrev;
  logic        resReqPrev;
  logic        resAckPrev;
  // expected {en, fine, ldConfl, except, hasConfl} per bundle, in send order
  logic [45:0] expQ [$];

  tbClock i_tbClock (
    .clk (clk),
    .rst (rst)
  );

  lsqCheckTop i_lsqCheckTop (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .opValid       (opValid),
    .opStore       (opStore),
    .opAddr        (opAddr),
    .opSize        (opSize),
    .opInst        (opInst),
    .ack           (ack),
    .resAck        (resAck),
    .resReq        (resReq),
    .retireEn      (retireEn),
    .retireFine    (retireFine),
    .retireLdConfl (retireLdConfl),
    .retireExcept  (retireExcept),
    .hasConfl      (hasConfl)
  );

  function automatic logic [31:0] nextRand(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state ^ (state >> 15);
  endfunction

  // expected result from the ordering rules, word ranges instead of banks
  function automatic logic [45:0] predict();
    instMask en;
    instMask fine;
    instMask ldc;
    instMask exc;
    slotMask bad;
    slotMask hc;
    int      lo [`LSQ_SLOTS];
    int      hi [`LSQ_SLOTS];
    en  = '0;
    ldc = '0;
    exc = '0;
    hc  = '0;
    for (int s = 0; s < `LSQ_SLOTS; s++) begin
      lo[s]  = int'(opAddr[s]);
      hi[s]  = lo[s] + int'(opSize[s]) - 1;
      bad[s] = opValid[s] && (opSize[s] == 5'd0 || opSize[s] > 5'd16 ||
                              (lo[s] >> 12) != (hi[s] >> 12));
    end
    // a later valid load against every earlier valid store
    for (int h = 1; h < `LSQ_SLOTS; h++) begin
      for (int k = 0; k < h; k++) begin
        if (opValid[h] && !opStore[h] && !bad[h] && opValid[k] && opStore[k] && !bad[k] &&
            (lo[h] >> 2) <= (hi[k] >> 2) && (lo[k] >> 2) <= (hi[h] >> 2)) begin
          hc[h] = 1'b1;
        end
      end
    end
    for (int i = 0; i < `LSQ_INSTS; i++) begin
      for (int s = 0; s < `LSQ_SLOTS; s++) begin
        if (opValid[s] && opInst[s] == instIdx'(i)) begin
          en[i]  = 1'b1;
          ldc[i] = ldc[i] | hc[s];
          exc[i] = exc[i] | bad[s];
        end
      end
    end
    fine = en & ~ldc & ~exc;
    return {en, fine, ldc, exc, hc};
  endfunction

  // mode 1 squeezes the indices to 0..3 so slots share entries
  task automatic makeBundle(input int mode);
    logic [31:0] r;
    for (int s = 0; s < `LSQ_SLOTS; s++) begin
      r = nextRand(seed);
      opValid[s] = r[24] | r[25];
      opStore[s] = r[26];
      // window around a page boundary, rarely the top of memory
      if (r[3:0] == 4'd0) begin
        opAddr[s] = 20'hFFFF0 + lsAddr'(r[7:4]);
      end else begin
        opAddr[s] = 20'h00F80 + lsAddr'(r[15:8] % 8'd192);
      end
      if (r[18:16] == 3'd0) begin
        opSize[s] = (r[23:19] > 5'd16) ? r[23:19] : 5'd0;
      end else begin
        opSize[s] = 5'd1 + {1'b0, r[23:20]};
      end
      opInst[s] = (mode == 1) ? instIdx'(r[28:27]) : instIdx'(r[31:27] % 5'd10);
    end
  endtask

  task automatic abortRun(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    $display("checks %0d errors %0d", checks, errors + 1);
    $display("TB FAILED");
    $finish;
  endtask

  function automatic logic sigValue(input int which);
    case (which)
      0: return ack;
      1: return resReq;
      default: return rst;
    endcase
  endfunction

  task automatic waitLevel(input int which, input logic level, input string what);
    int t;
    t = 0;
    while (sigValue(which) !== level) begin
      if (t == Timeout) abortRun(what);
      @(posedge clk);
      #1;
      t++;
    end
  endtask

  task automatic compareField(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic sendBundle(input int mode);
    int hold;
    waitLevel(0, 1'b0, "ack low before a new req");
    makeBundle(mode);
    expQ.push_back(predict());
    req = 1'b1;
    waitLevel(0, 1'b1, "ack");
    accepted++;
    if (accepted - retired > maxInFlight) maxInFlight = accepted - retired;
    // req sometimes stays up past ack, and ack has to wait for it
    hold = int'(nextRand(seed) % 32'd3);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
  endtask

  task automatic receiveResult();
    logic [45:0] exp;
    int          delay;
    waitLevel(1, 1'b1, "resReq");
    delay = slowAck ? 40 + int'(nextRand(ackSeed) % 32'd24) : int'(nextRand(ackSeed) % 32'd4);
    repeat (delay) begin
      @(posedge clk);
      #1;
    end
    if (expQ.size() == 0) begin
      errors++;
      $display("** Error: result arrived with no bundle outstanding at %0t", $time);
    end else begin
      exp = expQ.pop_front();
      compareField("retireEn", 16'(retireEn), 16'(exp[45:36]));
      compareField("retireFine", 16'(retireFine), 16'(exp[35:26]));
      compareField("retireLdConfl", 16'(retireLdConfl), 16'(exp[25:16]));
      compareField("retireExcept", 16'(retireExcept), 16'(exp[15:6]));
      compareField("hasConfl", 16'(hasConfl), 16'(exp[5:0]));
    end
    resAck = 1'b1;
    waitLevel(1, 1'b0, "resReq low");
    resAck = 1'b0;
    retired++;
  endtask

  // handshake ordering, sampled half a cycle away from both edges of activity
  always @(negedge clk) begin
    if (!rst) begin
      if (ack && !ackPrev && !reqPrev) begin
        errors++;
        $display("** Error: ack rose while req was low at %0t", $time);
      end
      if (!ack && ackPrev && reqPrev) begin
        errors++;
        $display("** Error: ack fell while req was still high at %0t", $time);
      end
      if (!resReq && resReqPrev && !resAckPrev) begin
        errors++;
        $display("** Error: resReq fell without resAck at %0t", $time);
      end
      if (accepted - retired > 2) begin
        errors++;
        $display("** Error: more than two bundles in flight at %0t", $time);
      end
    end
    ackPrev    = ack;
    reqPrev    = req;
    resReqPrev = resReq;
    resAckPrev = resAck;
  end

  initial begin
    seed        = 32'h9845_99d2;
    ackSeed     = nextRand(seed);
    errors      = 0;
    checks      = 0;
    accepted    = 0;
    retired     = 0;
    maxInFlight = 0;
    slowAck     = 1'b0;
    ackPrev     = 1'b0;
    reqPrev     = 1'b0;
    resReqPrev  = 1'b0;
    resAckPrev  = 1'b0;
    req         = 1'b0;
    resAck      = 1'b0;
    opValid     = '0;
    opStore     = '0;
    for (int s = 0; s < `LSQ_SLOTS; s++) begin
      opAddr[s] = '0;
      opSize[s] = '0;
      opInst[s] = '0;
    end

    waitLevel(2, 1'b0, "reset release");
    compareField("ack", 16'(ack), 16'h0);
    compareField("resReq", 16'(resReq), 16'h0);
    compareField("retireEn", 16'(retireEn), 16'h0);
    compareField("retireFine", 16'(retireFine), 16'h0);
    compareField("retireLdConfl", 16'(retireLdConfl), 16'h0);
    compareField("retireExcept", 16'(retireExcept), 16'h0);
    compareField("hasConfl", 16'(hasConfl), 16'h0);

    fork
      begin
        for (int n = 0; n < NumBundles; n++) begin
          // last stretch holds resAck off so the pipe fills up
          if (n == SlowStart) begin
            slowAck     = 1'b1;
            maxInFlight = 0;
          end
          sendBundle((n >= FoldStart && n < SlowStart) ? 1 : 0);
        end
      end
      begin
        repeat (NumBundles) receiveResult();
      end
    join

    if (maxInFlight != 2) begin
      errors++;
      $display("** Error: back-pressure never held two bundles, max was %0d", maxInFlight);
    end
    repeat (20) @(posedge clk);
    #1;
    if (resReq !== 1'b0 || expQ.size() != 0) begin
      errors++;
      $display("** Error: extra or missing results after the last bundle");
    end

    $display("bundles %0d checks %0d errors %0d", retired, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
source/lsqPkg.sv
source/lsqAddrDecode.sv
source/lsqConflictCheck.sv
source/lsqConflictBundle.sv
source/lsqRetireDecide.sv
source/lsqCheckTop.sv
sim/tbClock.sv
sim/tbLsqCheck.sv

// ==== Makefile ====
TOP := tbLsqCheck
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
